/* Bender.yml */
package:
  name: instr_decoder

sources:
  - isa_pkg.sv
  - ctrl_pkg.sv
  - decode_ctrl_if.sv
  - scalar_decoder.sv
  - vector_decoder.sv
  - decode_select_reg.sv
  - instr_decoder.sv
  - target: simulation
    files:
      - instr_decoder_props.sv
      - tb_instr_decoder.sv

/* ctrl_pkg.sv */
// decoded control class encodings
// first member of every enum is the NOP value
// default datapath / immediate width
package ctrl_pkg;

    localparam int default_xlen = 64;

    typedef enum logic [3:0] {
        exe_none,
        exe_binary,
        exe_imm_binary,
        exe_binary_word,
        exe_imm_binary_word,
        exe_mem_addr,
        exe_vec_mem_addr,
        exe_branch_cond,
        exe_imm,
        exe_pc_based,
        exe_read_csr,
        exe_set_cfg
    } exe_t;

    typedef enum logic [1:0] {
        vo_not_vec_arith,
        vo_vec_vec,
        vo_vec_imm,
        vo_vec_scalar
    } vec_opnd_t;

    typedef enum logic [1:0] {mem_nop, mem_load, mem_store} mem_vis_t;

    typedef enum logic [2:0] {
        ds_not_access,
        ds_one_byte,
        ds_two_bytes,
        ds_four_bytes,
        ds_eight_bytes
    } data_size_t;

    typedef enum logic [1:0] {vls_not_access, vls_stride, vls_whole_reg, vls_mask} vls_t;

    typedef enum logic [1:0] {
        br_not_branch,
        br_conditional,
        br_unconditional,
        br_unconditional_result  // jalr, target from alu
    } branch_t;

    typedef enum logic [2:0] {
        wb_nop,
        wb_arith,
        wb_mem_to_reg,
        wb_increased_pc,
        wb_csr_to_reg
    } wb_t;

endpackage

/* decode_ctrl_if.sv */
// control bundle from one decoder to the select stage
// combinational, no handshake
interface decode_ctrl_if #(parameter int xlen = ctrl_pkg::default_xlen);
    import ctrl_pkg::*;

    logic [xlen-1:0] imm;
    exe_t            exe;
    vec_opnd_t       vec_opnd;
    mem_vis_t        mem_vis;
    data_size_t      data_size;
    vls_t            vls;
    branch_t         branch;
    wb_t             wb;
    logic            illegal;

    modport producer (
        output imm, exe, vec_opnd, mem_vis, data_size, vls, branch, wb, illegal
    );

    modport consumer (
        input imm, exe, vec_opnd, mem_vis, data_size, vls, branch, wb, illegal
    );

endinterface

/* decode_select_reg.sv */
// scalar / vector bundle select, field extraction
// output register stage, one cycle latency
module decode_select_reg #(parameter int xlen = ctrl_pkg::default_xlen) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  isa_pkg::instr_word_t   instr,
    decode_ctrl_if.consumer        scalar_ctrl,
    decode_ctrl_if.consumer        vector_ctrl,
    output logic                   out_valid,
    output logic                   is_vector,
    output logic [4:0]             rs1, rs2, rd,
    output logic [11:0]            csr_addr,
    output logic                   vm,
    output logic [10:0]            zimm,
    output logic [5:0]             func6,
    output logic [3:0]             func_code,
    output logic [xlen-1:0]        imm,
    output ctrl_pkg::exe_t         exe,
    output ctrl_pkg::vec_opnd_t    vec_opnd,
    output ctrl_pkg::mem_vis_t     mem_vis,
    output ctrl_pkg::data_size_t   data_size,
    output ctrl_pkg::vls_t         vls,
    output ctrl_pkg::branch_t      branch,
    output ctrl_pkg::wb_t          wb,
    output logic                   illegal
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic            vec_sel;
    logic            sel_illegal;
    logic [xlen-1:0] sel_imm;
    exe_t            sel_exe;
    vec_opnd_t       sel_vec_opnd;
    mem_vis_t        sel_mem_vis;
    data_size_t      sel_data_size;
    vls_t            sel_vls;
    branch_t         sel_branch;
    wb_t             sel_wb;

    assign vec_sel = instr.v.opcode inside {opc_vl, opc_vs, opc_varith};

    always_comb begin
        sel_illegal   = vec_sel ? vector_ctrl.illegal   : scalar_ctrl.illegal;
        sel_imm       = vec_sel ? vector_ctrl.imm       : scalar_ctrl.imm;
        sel_exe       = vec_sel ? vector_ctrl.exe       : scalar_ctrl.exe;
        sel_vec_opnd  = vec_sel ? vector_ctrl.vec_opnd  : scalar_ctrl.vec_opnd;
        sel_mem_vis   = vec_sel ? vector_ctrl.mem_vis   : scalar_ctrl.mem_vis;
        sel_data_size = vec_sel ? vector_ctrl.data_size : scalar_ctrl.data_size;
        sel_vls       = vec_sel ? vector_ctrl.vls       : scalar_ctrl.vls;
        sel_branch    = vec_sel ? vector_ctrl.branch    : scalar_ctrl.branch;
        sel_wb        = vec_sel ? vector_ctrl.wb        : scalar_ctrl.wb;
        // bad encoding goes down the pipe as a nop
        if (sel_illegal) begin
            sel_imm       = '0;
            sel_exe       = exe_none;
            sel_vec_opnd  = vo_not_vec_arith;
            sel_mem_vis   = mem_nop;
            sel_data_size = ds_not_access;
            sel_vls       = vls_not_access;
            sel_branch    = br_not_branch;
            sel_wb        = wb_nop;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            is_vector <= 1'b0;
            rs1       <= '0;
            rs2       <= '0;
            rd        <= '0;
            csr_addr  <= '0;
            vm        <= 1'b0;
            zimm      <= '0;
            func6     <= '0;
            func_code <= '0;
            imm       <= '0;
            exe       <= exe_none;
            vec_opnd  <= vo_not_vec_arith;
            mem_vis   <= mem_nop;
            data_size <= ds_not_access;
            vls       <= vls_not_access;
            branch    <= br_not_branch;
            wb        <= wb_nop;
            illegal   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin  // outputs hold between instructions
                is_vector <= vec_sel;
                rs1       <= instr.s.rs1;
                rs2       <= instr.s.rs2;
                rd        <= instr.s.rd;
                csr_addr  <= {instr.s.funct7, instr.s.rs2};
                vm        <= instr.v.vm;
                zimm      <= {instr.v.funct6[4:0], instr.v.vm, instr.v.lumop};
                func6     <= instr.v.funct6;
                func_code <= {instr.s.funct7[5], instr.s.funct3};
                imm       <= sel_imm;
                exe       <= sel_exe;
                vec_opnd  <= sel_vec_opnd;
                mem_vis   <= sel_mem_vis;
                data_size <= sel_data_size;
                vls       <= sel_vls;
                branch    <= sel_branch;
                wb        <= sel_wb;
                illegal   <= sel_illegal;
            end
        end
    end

endmodule

/* instr_decoder.sv */
// instruction decode stage top level
// scalar and vector decoders feeding the select / register stage
module instr_decoder #(parameter int xlen = ctrl_pkg::default_xlen) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [31:0]            instr,
    output logic                   out_valid,
    output logic                   is_vector,
    output logic [4:0]             rs1, rs2, rd,
    output logic [11:0]            csr_addr,
    output logic                   vm,
    output logic [10:0]            zimm,
    output logic [5:0]             func6,
    output logic [3:0]             func_code,
    output logic [xlen-1:0]        imm,
    output ctrl_pkg::exe_t         exe,
    output ctrl_pkg::vec_opnd_t    vec_opnd,
    output ctrl_pkg::mem_vis_t     mem_vis,
    output ctrl_pkg::data_size_t   data_size,
    output ctrl_pkg::vls_t         vls,
    output ctrl_pkg::branch_t      branch,
    output ctrl_pkg::wb_t          wb,
    output logic                   illegal
);
    import isa_pkg::*;

    instr_word_t instr_w;

    assign instr_w = instr;

    decode_ctrl_if #(.xlen(xlen)) scalar_ctrl ();
    decode_ctrl_if #(.xlen(xlen)) vector_ctrl ();

    scalar_decoder #(.xlen(xlen)) u_scalar (
        .instr (instr_w),
        .ctrl  (scalar_ctrl)
    );

    vector_decoder #(.xlen(xlen)) u_vector (
        .instr (instr_w),
        .ctrl  (vector_ctrl)
    );

    decode_select_reg #(.xlen(xlen)) u_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .instr       (instr_w),
        .scalar_ctrl (scalar_ctrl),
        .vector_ctrl (vector_ctrl),
        .out_valid   (out_valid),
        .is_vector   (is_vector),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .csr_addr    (csr_addr),
        .vm          (vm),
        .zimm        (zimm),
        .func6       (func6),
        .func_code   (func_code),
        .imm         (imm),
        .exe         (exe),
        .vec_opnd    (vec_opnd),
        .mem_vis     (mem_vis),
        .data_size   (data_size),
        .vls         (vls),
        .branch      (branch),
        .wb          (wb),
        .illegal     (illegal)
    );

endmodule

/* instr_decoder_props.sv */
// bound checker for the decode stage
// reference decode of the last accepted word
// concurrent assertions on latency, reset state, hold, fields, immediate and controls
module instr_decoder_props #(parameter int xlen = ctrl_pkg::default_xlen) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid,
    input logic [31:0]          instr,
    input logic                 out_valid,
    input logic                 is_vector,
    input logic [4:0]           rs1, rs2, rd,
    input logic [11:0]          csr_addr,
    input logic                 vm,
    input logic [10:0]          zimm,
    input logic [5:0]           func6,
    input logic [3:0]           func_code,
    input logic [xlen-1:0]      imm,
    input ctrl_pkg::exe_t       exe,
    input ctrl_pkg::vec_opnd_t  vec_opnd,
    input ctrl_pkg::mem_vis_t   mem_vis,
    input ctrl_pkg::data_size_t data_size,
    input ctrl_pkg::vls_t       vls,
    input ctrl_pkg::branch_t    branch,
    input ctrl_pkg::wb_t        wb,
    input logic                 illegal
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    int unsigned     fail_count = 0;  // read by the testbench
    logic [31:0]     pw;               // word accepted last cycle
    logic            pv, seen;
    logic [6:0]      op;
    logic [2:0]      f3;
    logic [4:0]      lumop;
    logic            e_vec, e_ill, nop_ctrl;
    logic [xlen-1:0] e_imm;
    exe_t            e_exe;
    vec_opnd_t       e_vo;
    mem_vis_t        e_mem;
    data_size_t      e_ds;
    vls_t            e_vls;
    branch_t         e_br;
    wb_t             e_wb;
    logic [49:0]     e_fields, act_fields;
    logic [13:0]     e_ctrl, act_ctrl;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pv   <= 1'b0;
            seen <= 1'b0;
        end else begin
            pv <= in_valid;
            if (in_valid) begin
                seen <= 1'b1;
                pw   <= instr;
            end
        end
    end

    always_comb begin
        op     = pw[6:0];
        f3     = pw[14:12];
        lumop  = pw[24:20];
        e_vec  = op inside {opc_vl, opc_vs, opc_varith};
        e_ill  = 1'b0;
        e_imm  = '0;
        e_exe  = exe_none;
        e_vo   = vo_not_vec_arith;
        e_mem  = mem_nop;
        e_ds   = ds_not_access;
        e_vls  = vls_not_access;
        e_br   = br_not_branch;
        e_wb   = wb_nop;
        case (op)
            opc_system: begin
                if (f3 == f3_csrrs) begin
                    e_exe = exe_read_csr;
                    e_wb  = wb_csr_to_reg;
                    e_imm = xlen'(pw[19:15]);  // zimm zero extended
                end else begin
                    e_ill = 1'b1;
                end
            end
            opc_op, opc_op_w: begin
                e_exe = (op == opc_op) ? exe_binary : exe_binary_word;
                e_wb  = wb_arith;
            end
            opc_op_imm: begin
                e_exe = exe_imm_binary;
                e_wb  = wb_arith;
                if (!({pw[30], f3} inside {4'b0001, 4'b0101, 4'b1101}))
                    e_imm = xlen'($signed(pw[31:20]));
            end
            opc_op_imm_w, opc_jalr: begin
                if (f3 != 3'b000) begin
                    e_ill = 1'b1;
                end else begin
                    e_imm = xlen'($signed(pw[31:20]));
                    e_exe = (op == opc_jalr) ? exe_mem_addr : exe_imm_binary_word;
                    e_br  = (op == opc_jalr) ? br_unconditional_result : br_not_branch;
                    e_wb  = (op == opc_jalr) ? wb_increased_pc : wb_arith;
                end
            end
            opc_load, opc_store: begin
                if (f3[2]) begin
                    e_ill = 1'b1;
                end else begin
                    e_exe = exe_mem_addr;
                    e_mem = (op == opc_load) ? mem_load : mem_store;
                    e_wb  = (op == opc_load) ? wb_mem_to_reg : wb_nop;
                    e_ds  = data_size_t'({1'b0, f3[1:0]} + 3'd1);  // log2 bytes plus one
                    e_imm = (op == opc_load) ? xlen'($signed(pw[31:20]))
                                             : xlen'($signed({pw[31:25], pw[11:7]}));
                end
            end
            opc_branch: begin
                e_exe = exe_branch_cond;
                e_br  = br_conditional;
                e_imm = xlen'($signed({pw[31], pw[7], pw[30:25], pw[11:8], 1'b0}));
            end
            opc_jal: begin
                if (f3 != 3'b000) begin
                    e_ill = 1'b1;
                end else begin
                    e_exe = exe_pc_based;
                    e_br  = br_unconditional;
                    e_wb  = wb_increased_pc;
                    e_imm = xlen'($signed({pw[31], pw[19:12], pw[20], pw[30:21], 1'b0}));
                end
            end
            opc_lui, opc_auipc: begin
                e_exe = (op == opc_lui) ? exe_imm : exe_pc_based;
                e_wb  = wb_arith;
                e_imm = xlen'($signed({pw[31:12], 12'b0}));
            end
            opc_vl, opc_vs: begin
                if (!(f3 inside {3'b000, 3'b101, 3'b110, 3'b111})
                        || !(lumop inside {lumop_basic, lumop_whole_reg, lumop_mask})) begin
                    e_ill = 1'b1;
                end else begin
                    e_imm = xlen'($signed(pw[19:15]));
                    e_exe = exe_vec_mem_addr;
                    e_mem = (op == opc_vl) ? mem_load : mem_store;
                    e_wb  = (op == opc_vl) ? wb_mem_to_reg : wb_nop;
                    e_ds  = data_size_t'({1'b0, f3[1:0]} + 3'd1);  // 000,101,110,111 map alike
                    e_vls = (lumop == lumop_basic) ? vls_stride
                          : (lumop == lumop_whole_reg) ? vls_whole_reg : vls_mask;
                end
            end
            opc_varith: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    e_ill = 1'b1;
                end else begin
                    e_imm = xlen'($signed(pw[19:15]));
                    e_wb  = wb_arith;
                    case (f3)
                        f3_opivv, f3_opmvv: begin
                            e_exe = exe_binary;
                            e_vo  = vo_vec_vec;
                        end
                        f3_opivi: begin
                            e_exe = exe_imm_binary;
                            e_vo  = vo_vec_imm;
                        end
                        f3_opivx, f3_opmvx: begin
                            e_exe = exe_binary;
                            e_vo  = vo_vec_scalar;
                        end
                        default: e_exe = exe_set_cfg;
                    endcase
                end
            end
            default: e_ill = 1'b1;
        endcase
    end

    assign e_fields   = {pw[19:15], pw[24:20], pw[11:7], pw[31:20], pw[25], pw[30:20],
                         pw[31:26], pw[30], pw[14:12], e_vec};
    assign act_fields = {rs1, rs2, rd, csr_addr, vm, zimm, func6, func_code, is_vector};
    assign e_ctrl     = {e_vo, e_mem, e_ds, e_vls, e_br, e_wb};
    assign act_ctrl   = {vec_opnd, mem_vis, data_size, vls, branch, wb};
    assign nop_ctrl   = exe == exe_none && vec_opnd == vo_not_vec_arith && mem_vis == mem_nop
                     && data_size == ds_not_access && vls == vls_not_access
                     && branch == br_not_branch && wb == wb_nop;

    a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
        !seen |-> !out_valid && !illegal && imm == '0 && nop_ctrl)
        else begin
            fail_count++;
            $error("outputs left their reset values before any instruction at %0t", $time);
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n) out_valid == pv)
        else begin
            fail_count++;
            $error("Mismatch at %0t: out_valid got %b expected %b",
                   $time, $sampled(out_valid), $sampled(pv));
        end

    // no accepted word, nothing moves
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !in_valid |=> $stable({act_fields, act_ctrl, exe, imm, illegal}))
        else begin
            fail_count++;
            $error("outputs changed at %0t after a cycle with in_valid low", $time);
        end

    a_fields: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> act_fields == e_fields)
        else begin
            fail_count++;
            $error("Mismatch at %0t: %s got %h expected %h", $time,
                   "{rs1,rs2,rd,csr_addr,vm,zimm,func6,func_code,is_vector}",
                   $sampled(act_fields), $sampled(e_fields));
        end

    a_imm: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> imm == e_imm)
        else begin
            fail_count++;
            $error("Mismatch at %0t: imm got %h expected %h",
                   $time, $sampled(imm), $sampled(e_imm));
        end

    a_exe: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> exe == e_exe)
        else begin
            fail_count++;
            $error("Mismatch at %0t: exe got %0d expected %0d",
                   $time, $sampled(exe), $sampled(e_exe));
        end

    a_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> act_ctrl == e_ctrl)
        else begin
            fail_count++;
            $error("Mismatch at %0t: %s got %h expected %h", $time,
                   "{vec_opnd,mem_vis,data_size,vls,branch,wb}",
                   $sampled(act_ctrl), $sampled(e_ctrl));
        end

    a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> illegal == e_ill)
        else begin
            fail_count++;
            $error("Mismatch at %0t: illegal got %b expected %b",
                   $time, $sampled(illegal), $sampled(e_ill));
        end

endmodule

bind instr_decoder instr_decoder_props #(.xlen(xlen)) u_props (.*);

/* isa_pkg.sv */
// RV64 base and vector extension encodings
// major opcodes, funct3 codes, vector element widths and lumop values
// instruction word union with scalar and vector field views
package isa_pkg;

    // major opcodes
    localparam logic [6:0] opc_load     = 7'b0000011;
    localparam logic [6:0] opc_op_imm   = 7'b0010011;
    localparam logic [6:0] opc_op_imm_w = 7'b0011011;
    localparam logic [6:0] opc_op       = 7'b0110011;
    localparam logic [6:0] opc_op_w     = 7'b0111011;
    localparam logic [6:0] opc_store    = 7'b0100011;
    localparam logic [6:0] opc_branch   = 7'b1100011;
    localparam logic [6:0] opc_jalr     = 7'b1100111;
    localparam logic [6:0] opc_jal      = 7'b1101111;
    localparam logic [6:0] opc_lui      = 7'b0110111;
    localparam logic [6:0] opc_auipc    = 7'b0010111;
    localparam logic [6:0] opc_system   = 7'b1110011;
    localparam logic [6:0] opc_vl       = 7'b0000111;
    localparam logic [6:0] opc_vs       = 7'b0100111;
    localparam logic [6:0] opc_varith   = 7'b1010111;

    localparam logic [2:0] f3_csrrs = 3'b010;

    // vector arithmetic / config categories
    localparam logic [2:0] f3_opivv = 3'b000;
    localparam logic [2:0] f3_opmvv = 3'b010;
    localparam logic [2:0] f3_opivi = 3'b011;
    localparam logic [2:0] f3_opivx = 3'b100;
    localparam logic [2:0] f3_opmvx = 3'b110;
    localparam logic [2:0] f3_opcfg = 3'b111;

    // vector memory element width
    localparam logic [2:0] w_8bit  = 3'b000;
    localparam logic [2:0] w_16bit = 3'b101;
    localparam logic [2:0] w_32bit = 3'b110;
    localparam logic [2:0] w_64bit = 3'b111;

    localparam logic [4:0] lumop_basic     = 5'b00000;
    localparam logic [4:0] lumop_whole_reg = 5'b01000;
    localparam logic [4:0] lumop_mask      = 5'b01011;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [5:0] funct6;
            logic       vm;
            logic [4:0] lumop;  // vs2 on arithmetic
            logic [4:0] rs1;
            logic [2:0] width;  // funct3 on arithmetic
            logic [4:0] vd;
            logic [6:0] opcode;
        } v;
    } instr_word_t;

endpackage

/* scalar_decoder.sv */
// scalar instruction decoder
// P/R/I/S/B/U/J format classification, immediate generation, control classes
module scalar_decoder #(parameter int xlen = ctrl_pkg::default_xlen) (
    input isa_pkg::instr_word_t instr,
    decode_ctrl_if.producer     ctrl
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [31:0]     w;
    logic [6:0]      op;
    logic [2:0]      f3;
    logic            shift_imm;
    logic            p_fmt, r_fmt, i_fmt, s_fmt, b_fmt, u_fmt, j_fmt;
    logic            legal;
    logic [xlen-1:0] p_imm, i_imm, s_imm, b_imm, u_imm, j_imm;

    function automatic data_size_t size_of(input logic [1:0] f);
        case (f)
            2'b00:   return ds_one_byte;
            2'b01:   return ds_two_bytes;
            2'b10:   return ds_four_bytes;
            default: return ds_eight_bytes;
        endcase
    endfunction

    assign w  = instr;
    assign op = instr.s.opcode;
    assign f3 = instr.s.funct3;

    // slli/srli/srai land in R format, immediate dropped
    assign shift_imm = {instr.s.funct7[5], f3} inside {4'b0001, 4'b0101, 4'b1101};

    assign p_fmt = op == opc_system && f3 == f3_csrrs;
    assign r_fmt = op == opc_op || op == opc_op_w || (op == opc_op_imm && shift_imm);
    assign i_fmt = (op == opc_op_imm && !shift_imm)
                || (op == opc_load && !f3[2])
                || ((op == opc_jalr || op == opc_op_imm_w) && f3 == 3'b000);
    assign s_fmt = op == opc_store && !f3[2];
    assign b_fmt = op == opc_branch;
    assign u_fmt = op == opc_lui || op == opc_auipc;
    assign j_fmt = op == opc_jal && f3 == 3'b000;
    assign legal = p_fmt | r_fmt | i_fmt | s_fmt | b_fmt | u_fmt | j_fmt;

    assign p_imm = {{(xlen-5){1'b0}}, instr.s.rs1};  // csr zimm
    assign i_imm = {{(xlen-12){w[31]}}, w[31:20]};
    assign s_imm = {{(xlen-12){w[31]}}, w[31:25], w[11:7]};
    assign b_imm = {{(xlen-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    assign u_imm = {{(xlen-32){w[31]}}, w[31:12], 12'b0};
    assign j_imm = {{(xlen-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

    always_comb begin
        if (p_fmt)      ctrl.imm = p_imm;
        else if (i_fmt) ctrl.imm = i_imm;
        else if (s_fmt) ctrl.imm = s_imm;
        else if (b_fmt) ctrl.imm = b_imm;
        else if (u_fmt) ctrl.imm = u_imm;
        else if (j_fmt) ctrl.imm = j_imm;
        else            ctrl.imm = '0;  // R format and illegal
    end

    always_comb begin
        ctrl.exe       = exe_none;
        ctrl.vec_opnd  = vo_not_vec_arith;
        ctrl.mem_vis   = mem_nop;
        ctrl.data_size = ds_not_access;
        ctrl.vls       = vls_not_access;
        ctrl.branch    = br_not_branch;
        ctrl.wb        = wb_nop;
        if (legal) begin
            case (op)
                opc_system: begin
                    ctrl.exe = exe_read_csr;
                    ctrl.wb  = wb_csr_to_reg;
                end
                opc_op, opc_op_w: begin
                    ctrl.exe = (op == opc_op) ? exe_binary : exe_binary_word;
                    ctrl.wb  = wb_arith;
                end
                opc_op_imm, opc_op_imm_w: begin
                    ctrl.exe = (op == opc_op_imm) ? exe_imm_binary : exe_imm_binary_word;
                    ctrl.wb  = wb_arith;
                end
                opc_load, opc_store: begin
                    ctrl.exe       = exe_mem_addr;
                    ctrl.mem_vis   = (op == opc_load) ? mem_load : mem_store;
                    ctrl.data_size = size_of(f3[1:0]);
                    ctrl.wb        = (op == opc_load) ? wb_mem_to_reg : wb_nop;
                end
                opc_branch: begin
                    ctrl.exe    = exe_branch_cond;
                    ctrl.branch = br_conditional;
                end
                opc_jalr: begin
                    ctrl.exe    = exe_mem_addr;  // rs1 + imm via the alu
                    ctrl.branch = br_unconditional_result;
                    ctrl.wb     = wb_increased_pc;
                end
                opc_jal: begin
                    ctrl.exe    = exe_pc_based;
                    ctrl.branch = br_unconditional;
                    ctrl.wb     = wb_increased_pc;
                end
                opc_lui, opc_auipc: begin
                    ctrl.exe = (op == opc_lui) ? exe_imm : exe_pc_based;
                    ctrl.wb  = wb_arith;
                end
                default: ;
            endcase
        end
    end

    assign ctrl.illegal = !legal;  // vector opcodes included

endmodule

/* sim.f */
isa_pkg.sv
ctrl_pkg.sv
decode_ctrl_if.sv
scalar_decoder.sv
vector_decoder.sv
decode_select_reg.sv
instr_decoder.sv
instr_decoder_props.sv
tb_instr_decoder.sv

/* tb_instr_decoder.sv */
// testbench for the decode stage
// clock, reset, directed and random instruction words
// checking lives in the bound props module, failures counted there
module tb_instr_decoder;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int xlen = default_xlen;

    logic            clk, rst_n, in_valid;
    logic [31:0]     instr;
    logic            out_valid, is_vector, vm, illegal;
    logic [4:0]      rs1, rs2, rd;
    logic [11:0]     csr_addr;
    logic [10:0]     zimm;
    logic [5:0]      func6;
    logic [3:0]      func_code;
    logic [xlen-1:0] imm;
    exe_t            exe;
    vec_opnd_t       vec_opnd;
    mem_vis_t        mem_vis;
    data_size_t      data_size;
    vls_t            vls;
    branch_t         branch;
    wb_t             wb;

    int seed = 50254;
    int timeouts = 0;
    int issued = 0;

    // scalar formats, shifts, illegal scalar cases, then vector mem and arith
    logic [31:0] directed [$] = {
        32'h002081B3, 32'h402081B3, 32'h002081BB, 32'hFFB30293, 32'h00331293,
        32'h40435293, 32'h0073029B, 32'h0013129B, 32'hFF813383, 32'h00410383,
        32'h00411383, 32'h00412383, 32'h00414383, 32'h00417383, 32'hFE513823,
        32'h0051C023, 32'h00208863, 32'hFE209EE3, 32'h008000EF, 32'hFF5FF0EF,
        32'h008010EF, 32'h000280E7, 32'h000290E7, 32'h800002B7, 32'h12345297,
        32'h300022F3, 32'h300FA2F3, 32'h300292F3, 32'h00000073, 32'h0000007F,
        32'h0000000F, 32'h00050087, 32'h02055087, 32'h02056087, 32'h02057087,
        32'h02850087, 32'h02B50087, 32'h02150087, 32'h02051087, 32'h020500A7,
        32'h020570A7, 32'h022180D7, 32'h0221A0D7, 32'h022EB0D7, 32'h0221C0D7,
        32'h0221E0D7, 32'h0C0572D7, 32'h022190D7, 32'h0221D0D7, 32'h0A2180D7
    };

    logic [6:0] legal_ops [0:14] = '{
        opc_load, opc_op_imm, opc_op_imm_w, opc_op, opc_op_w, opc_store, opc_branch,
        opc_jalr, opc_jal, opc_lui, opc_auipc, opc_system, opc_vl, opc_vs, opc_varith
    };

    instr_decoder #(.xlen(xlen)) UUT (.*);

    always #10 clk = ~clk;

    // one word per edge, inputs change just after the edge
    task automatic drive(input logic valid, input logic [31:0] word);
        in_valid = valid;
        instr    = word;
        if (valid)
            issued++;
        @(posedge clk);
        #1;
    endtask

    task automatic await_out_valid(input logic level);
        int n;
        n = 0;
        while (out_valid !== level && n < 8) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (out_valid !== level) begin
            timeouts++;
            $display("time %0t: out_valid did not go %b within 8 cycles", $time, level);
        end
    endtask

    initial begin
        logic [31:0] word, pick;
        int          errors;
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) @(posedge clk);  // reset state seen with no input
        #1;

        foreach (directed[i]) begin
            drive(1'b1, directed[i]);
            await_out_valid(1'b1);
            if (i % 3 == 2) begin
                in_valid = 1'b0;
                instr    = ~directed[i];  // outputs must hold
                await_out_valid(1'b0);
            end
        end

        repeat (200) begin
            word = $random(seed);
            pick = $random(seed);
            if (pick[0])
                word[6:0] = legal_ops[pick[8:1] % 15];
            drive(1'b1, word);
            await_out_valid(1'b1);
            if (pick[12:10] == 3'd0) begin
                in_valid = 1'b0;
                await_out_valid(1'b0);
            end
        end

        in_valid = 1'b0;
        await_out_valid(1'b0);
        repeat (2) @(posedge clk);
        errors = UUT.u_props.fail_count;
        $display("closing: %0d instructions, %0d assertion failures, %0d timeouts",
                 issued, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* vector_decoder.sv */
// vector instruction decoder
// load/store width and lumop, arithmetic category, config
module vector_decoder #(parameter int xlen = ctrl_pkg::default_xlen) (
    input isa_pkg::instr_word_t instr,
    decode_ctrl_if.producer     ctrl
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [6:0] op;
    logic [2:0] f3;
    logic       mem_op, arith_op;
    logic       width_ok, lumop_ok, f3_ok;
    logic       bad;

    assign op       = instr.v.opcode;
    assign f3       = instr.v.width;
    assign mem_op   = op == opc_vl || op == opc_vs;
    assign arith_op = op == opc_varith;

    assign width_ok = f3 inside {w_8bit, w_16bit, w_32bit, w_64bit};
    assign lumop_ok = instr.v.lumop inside {lumop_basic, lumop_whole_reg, lumop_mask};
    assign f3_ok    = f3 inside {f3_opivv, f3_opmvv, f3_opivi, f3_opivx, f3_opmvx, f3_opcfg};

    assign bad = mem_op ? !(width_ok && lumop_ok) : arith_op ? !f3_ok : 1'b1;

    always_comb begin
        ctrl.imm       = '0;
        ctrl.exe       = exe_none;
        ctrl.vec_opnd  = vo_not_vec_arith;
        ctrl.mem_vis   = mem_nop;
        ctrl.data_size = ds_not_access;
        ctrl.vls       = vls_not_access;
        ctrl.branch    = br_not_branch;
        ctrl.wb        = wb_nop;
        if (!bad) begin
            ctrl.imm = {{(xlen-5){instr.v.rs1[4]}}, instr.v.rs1};  // simm5
            if (mem_op) begin
                ctrl.exe     = exe_vec_mem_addr;
                ctrl.mem_vis = (op == opc_vl) ? mem_load : mem_store;
                ctrl.wb      = (op == opc_vl) ? wb_mem_to_reg : wb_nop;
                case (f3)
                    w_8bit:  ctrl.data_size = ds_one_byte;
                    w_16bit: ctrl.data_size = ds_two_bytes;
                    w_32bit: ctrl.data_size = ds_four_bytes;
                    default: ctrl.data_size = ds_eight_bytes;
                endcase
                case (instr.v.lumop)
                    lumop_basic:     ctrl.vls = vls_stride;
                    lumop_whole_reg: ctrl.vls = vls_whole_reg;
                    default:         ctrl.vls = vls_mask;
                endcase
            end else begin
                ctrl.wb = wb_arith;
                case (f3)
                    f3_opivv, f3_opmvv: begin
                        ctrl.exe      = exe_binary;
                        ctrl.vec_opnd = vo_vec_vec;
                    end
                    f3_opivi: begin
                        ctrl.exe      = exe_imm_binary;
                        ctrl.vec_opnd = vo_vec_imm;
                    end
                    f3_opivx, f3_opmvx: begin
                        ctrl.exe      = exe_binary;
                        ctrl.vec_opnd = vo_vec_scalar;
                    end
                    default: ctrl.exe = exe_set_cfg;  // vsetvl family
                endcase
            end
        end
    end

    assign ctrl.illegal = bad;

endmodule
